//--- source/immu_defs.svh
// Widths, page geometry and TLB size of the instruction MMU
// Exception vectors, configuration register codes, entry and status bit positions

`ifndef IMMU_DEFS_SVH
`define IMMU_DEFS_SVH

// Address and register widths
`define IMMU_AW 32
`define IMMU_DW 32

// 8 KiB pages
`define IMMU_PAGE_SHIFT 13

// 16 TLB sets, must not exceed the VPN width
`define IMMU_TLB_AW 4

// Addresses sent with an exception
`define IMMU_EITM_VECTOR 32'h0000_0100
`define IMMU_EIPF_VECTOR 32'h0000_0180

// Configuration register select
`define IMMU_SEL_PSR  2'd0
`define IMMU_SEL_ID   2'd1
`define IMMU_SEL_TLBL 2'd2
`define IMMU_SEL_TLBH 2'd3

// Entry bits, VPN and PPN sit above the page offset
`define IMMU_TLBL_V_BIT  0
`define IMMU_TLBH_UX_BIT 3
`define IMMU_TLBH_RX_BIT 4

// Status register bits
`define IMMU_PSR_IMME_BIT 0
`define IMMU_PSR_RM_BIT   1

`endif

//--- source/immu_pkg.sv
// Instruction MMU types
// Address, word and page field vectors, configuration FSM states

`default_nettype none

`include "immu_defs.svh"

package immu_pkg;

   // Full addresses and 32-bit register or TLB words
   typedef logic [`IMMU_AW-1:0] addr_t;
   typedef logic [`IMMU_DW-1:0] word_t;

   // Page number and offset fields
   typedef logic [`IMMU_AW-`IMMU_PAGE_SHIFT-1:0] vpn_t;
   typedef logic [`IMMU_DW-`IMMU_PAGE_SHIFT-1:0] ppn_t;
   typedef logic [`IMMU_PAGE_SHIFT-1:0]          offset_t;

   // TLB set index
   typedef logic [`IMMU_TLB_AW-1:0] tlb_idx_t;

   // Bit 0 TLB miss, bit 1 page fault
   typedef logic [1:0] exc_t;

   // Configuration register select
   typedef logic [1:0] cfg_sel_t;

   // Four-phase handshake sequencing
   typedef enum logic [1:0] {IDLE, ACCESS, ACK, WAIT_DROP} csr_state_t;

endpackage

`default_nettype wire

//--- source/itlb_ram.sv
// Instruction TLB storage, tag words and data words
// Registered lookup read port, configuration read/write port

`timescale 1ns/1ps
`default_nettype none

`include "immu_defs.svh"

module itlb_ram (
   input  wire                     clk,
   input  wire                     rst,
   // Lookup side, read only
   input  wire                     lookup_en,
   input  wire immu_pkg::tlb_idx_t lookup_idx,
   output immu_pkg::word_t         lookup_lo,
   output immu_pkg::word_t         lookup_hi,
   // Configuration side
   input  wire                     cfg_en,
   input  wire                     cfg_we_lo,
   input  wire                     cfg_we_hi,
   input  wire immu_pkg::tlb_idx_t cfg_idx,
   input  wire immu_pkg::word_t    cfg_wdata,
   output immu_pkg::word_t         cfg_rdata_lo,
   output immu_pkg::word_t         cfg_rdata_hi
);

   localparam int unsigned NSETS = 1 << `IMMU_TLB_AW;

   // Tag words hold VPN and valid, data words hold PPN and permissions
   immu_pkg::word_t lo_mem [NSETS];
   immu_pkg::word_t hi_mem [NSETS];

   // Valid bits live in flops so a fresh TLB misses
   logic [NSETS-1:0] valid_r;

   // Tag word with its valid bit taken from the flop vector
   function automatic immu_pkg::word_t tag_word(input immu_pkg::word_t w, input logic v);
      immu_pkg::word_t r;
      r = w;
      r[`IMMU_TLBL_V_BIT] = v;
      return r;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_r <= '0;
      end else if (cfg_en && cfg_we_lo) begin
         valid_r[cfg_idx] <= cfg_wdata[`IMMU_TLBL_V_BIT];
      end
   end

   // Configuration port, write one half or read both
   always_ff @(posedge clk) begin
      if (cfg_en) begin
         if (cfg_we_lo) begin
            lo_mem[cfg_idx] <= cfg_wdata;
         end
         if (cfg_we_hi) begin
            hi_mem[cfg_idx] <= cfg_wdata;
         end
         cfg_rdata_lo <= tag_word(lo_mem[cfg_idx], valid_r[cfg_idx]);
         cfg_rdata_hi <= hi_mem[cfg_idx];
      end
   end

   // Lookup port
   // Output holds while the stage is stalled
   always_ff @(posedge clk) begin
      if (lookup_en) begin
         lookup_lo <= tag_word(lo_mem[lookup_idx], valid_r[lookup_idx]);
         lookup_hi <= hi_mem[lookup_idx];
      end
   end

endmodule

`default_nettype wire

//--- source/immu_csr.sv
// Instruction MMU configuration block
// Status bits, ID register and TLB access over a four-phase req/ack port

`timescale 1ns/1ps
`default_nettype none

`include "immu_defs.svh"

module immu_csr (
   input  wire                     clk,
   input  wire                     rst,
   // Host port
   input  wire                     cfg_req,
   input  wire                     cfg_write,
   input  wire immu_pkg::cfg_sel_t cfg_sel,
   input  wire immu_pkg::tlb_idx_t cfg_idx,
   input  wire immu_pkg::word_t    cfg_wdata,
   output logic                    cfg_ack,
   output immu_pkg::word_t         cfg_rdata,
   // Status bits steering translation
   output logic                    psr_imme,
   output logic                    psr_rm,
   // TLB configuration port
   output logic                    tlb_en,
   output logic                    tlb_we_lo,
   output logic                    tlb_we_hi,
   output immu_pkg::tlb_idx_t      tlb_idx,
   output immu_pkg::word_t         tlb_wdata,
   input  wire immu_pkg::word_t    tlb_rdata_lo,
   input  wire immu_pkg::word_t    tlb_rdata_hi
);

   // TLB size in the low 3 bits
   localparam immu_pkg::word_t ID_VALUE = immu_pkg::word_t'(`IMMU_TLB_AW & 7);

   immu_pkg::csr_state_t state;
   immu_pkg::csr_state_t state_nxt;

   // Command captured when req is first seen
   logic               cmd_write;
   immu_pkg::cfg_sel_t cmd_sel;
   immu_pkg::tlb_idx_t cmd_idx;
   immu_pkg::word_t    cmd_wdata;

   logic psr_we;

   always_comb begin
      state_nxt = state;
      case (state)
         immu_pkg::IDLE: begin
            if (cfg_req) begin
               state_nxt = immu_pkg::ACCESS;
            end
         end
         immu_pkg::ACCESS: state_nxt = immu_pkg::ACK;
         // Hold ack until the host lets go of req
         immu_pkg::ACK: begin
            if (!cfg_req) begin
               state_nxt = immu_pkg::WAIT_DROP;
            end
         end
         immu_pkg::WAIT_DROP: state_nxt = immu_pkg::IDLE;
         default: state_nxt = immu_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= immu_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (state == immu_pkg::IDLE && cfg_req) begin
         cmd_write <= cfg_write;
         cmd_sel   <= cfg_sel;
         cmd_idx   <= cfg_idx;
         cmd_wdata <= cfg_wdata;
      end
   end

   // Writes land at the ACCESS edge
   assign psr_we = (state == immu_pkg::ACCESS) && cmd_write && (cmd_sel == `IMMU_SEL_PSR);

   // Out of reset MMU off, supervisor mode
   always_ff @(posedge clk) begin
      if (rst) begin
         psr_imme <= 1'b0;
         psr_rm   <= 1'b1;
      end else if (psr_we) begin
         psr_imme <= cmd_wdata[`IMMU_PSR_IMME_BIT];
         psr_rm   <= cmd_wdata[`IMMU_PSR_RM_BIT];
      end
   end

   // TLB port driven in ACCESS only
   // Read data is registered in the RAM, ready by ACK
   assign tlb_en    = (state == immu_pkg::ACCESS);
   assign tlb_we_lo = tlb_en && cmd_write && (cmd_sel == `IMMU_SEL_TLBL);
   assign tlb_we_hi = tlb_en && cmd_write && (cmd_sel == `IMMU_SEL_TLBH);
   assign tlb_idx   = cmd_idx;
   assign tlb_wdata = cmd_wdata;

   // Ack stays up through the drop cycle
   assign cfg_ack = (state == immu_pkg::ACK) || (state == immu_pkg::WAIT_DROP);

   // Read mux, sources are stable while ack is high
   always_comb begin
      cfg_rdata = '0;
      case (cmd_sel)
         `IMMU_SEL_PSR: begin
            cfg_rdata[`IMMU_PSR_IMME_BIT] = psr_imme;
            cfg_rdata[`IMMU_PSR_RM_BIT]   = psr_rm;
         end
         `IMMU_SEL_ID:   cfg_rdata = ID_VALUE;
         `IMMU_SEL_TLBL: cfg_rdata = tlb_rdata_lo;
         default:        cfg_rdata = tlb_rdata_hi;
      endcase
   end

endmodule

`default_nettype wire

//--- source/immu_translate.sv
// Instruction address translation stage
// One-entry valid/ready pipeline, tag compare, execute check, exception select

`timescale 1ns/1ps
`default_nettype none

`include "immu_defs.svh"

module immu_translate (
   input  wire                     clk,
   input  wire                     rst,
   // Fetch side
   input  wire                     fetch_valid,
   output logic                    fetch_ready,
   input  wire immu_pkg::addr_t    fetch_addr,
   // Status bits from the configuration block
   input  wire                     psr_imme,
   input  wire                     psr_rm,
   // TLB lookup port
   output logic                    lookup_en,
   output immu_pkg::tlb_idx_t      lookup_idx,
   input  wire immu_pkg::word_t    lookup_lo,
   input  wire immu_pkg::word_t    lookup_hi,
   // Translated output
   output logic                    out_valid,
   input  wire                     out_ready,
   output immu_pkg::addr_t         out_addr,
   output immu_pkg::exc_t          out_exc
);

   localparam int unsigned PS = `IMMU_PAGE_SHIFT;
   localparam int unsigned AW = `IMMU_AW;
   localparam int unsigned DW = `IMMU_DW;

   // Exception flag positions
   localparam int unsigned EXC_ITM = 0;
   localparam int unsigned EXC_IPF = 1;

   logic accept;

   // Held item, status sampled with it
   immu_pkg::addr_t   addr_r;
   immu_pkg::vpn_t    vpn_r;
   immu_pkg::offset_t offset_r;
   logic              imme_r;
   logic              rm_r;

   // Fields of the entry read for the held item
   logic           tlb_v;
   logic           tlb_ux;
   logic           tlb_rx;
   immu_pkg::vpn_t tlb_vpn;
   immu_pkg::ppn_t tlb_ppn;

   logic           tlb_miss;
   logic           perm_denied;
   immu_pkg::exc_t exc;

   // Empty, or the held result leaves this cycle
   assign fetch_ready = !out_valid || out_ready;
   assign accept      = fetch_valid && fetch_ready;

   // TLB read starts on the accepting edge
   // Index is the low bits of the VPN
   assign lookup_en  = accept;
   assign lookup_idx = fetch_addr[PS +: `IMMU_TLB_AW];

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (fetch_ready) begin
         out_valid <= fetch_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_r   <= fetch_addr;
         vpn_r    <= fetch_addr[AW-1:PS];
         offset_r <= fetch_addr[PS-1:0];
         imme_r   <= psr_imme;
         rm_r     <= psr_rm;
      end
   end

   // Entry decode
   assign tlb_v   = lookup_lo[`IMMU_TLBL_V_BIT];
   assign tlb_vpn = lookup_lo[DW-1:PS];
   assign tlb_ux  = lookup_hi[`IMMU_TLBH_UX_BIT];
   assign tlb_rx  = lookup_hi[`IMMU_TLBH_RX_BIT];
   assign tlb_ppn = lookup_hi[DW-1:PS];

   // Full VPN compare catches aliases above the index
   assign tlb_miss = !(tlb_v && (tlb_vpn == vpn_r));

   // Supervisor checks rx, user checks ux
   assign perm_denied = rm_r ? !tlb_rx : !tlb_ux;

   // Fault only on a hit, so the two flags never overlap
   assign exc[EXC_ITM] = imme_r && tlb_miss;
   assign exc[EXC_IPF] = imme_r && !tlb_miss && perm_denied;

   assign out_exc = exc;

   always_comb begin
      if (!imme_r) begin
         // MMU off, pass through
         out_addr = addr_r;
      end else if (exc[EXC_ITM]) begin
         out_addr = `IMMU_EITM_VECTOR;
      end else if (exc[EXC_IPF]) begin
         out_addr = `IMMU_EIPF_VECTOR;
      end else begin
         out_addr = {tlb_ppn, offset_r};
      end
   end

endmodule

`default_nettype wire

//--- source/immu_top.sv
// Instruction MMU top level
// Configuration block, TLB storage and translation stage

`timescale 1ns/1ps
`default_nettype none

module immu_top (
   input  wire                     clk,
   input  wire                     rst,
   // Fetch input
   input  wire                     fetch_valid,
   output logic                    fetch_ready,
   input  wire immu_pkg::addr_t    fetch_addr,
   // Translated output
   output logic                    out_valid,
   input  wire                     out_ready,
   output immu_pkg::addr_t         out_addr,
   output immu_pkg::exc_t          out_exc,
   // Configuration port
   input  wire                     cfg_req,
   input  wire                     cfg_write,
   input  wire immu_pkg::cfg_sel_t cfg_sel,
   input  wire immu_pkg::tlb_idx_t cfg_idx,
   input  wire immu_pkg::word_t    cfg_wdata,
   output logic                    cfg_ack,
   output immu_pkg::word_t         cfg_rdata
);

   // Status bits
   logic psr_imme;
   logic psr_rm;

   // Configuration side of the TLB
   logic               tlb_en;
   logic               tlb_we_lo;
   logic               tlb_we_hi;
   immu_pkg::tlb_idx_t tlb_idx;
   immu_pkg::word_t    tlb_wdata;
   immu_pkg::word_t    tlb_rdata_lo;
   immu_pkg::word_t    tlb_rdata_hi;

   // Lookup side of the TLB
   logic               lookup_en;
   immu_pkg::tlb_idx_t lookup_idx;
   immu_pkg::word_t    lookup_lo;
   immu_pkg::word_t    lookup_hi;

   immu_csr i_immu_csr (
      .clk          (clk),
      .rst          (rst),
      .cfg_req      (cfg_req),
      .cfg_write    (cfg_write),
      .cfg_sel      (cfg_sel),
      .cfg_idx      (cfg_idx),
      .cfg_wdata    (cfg_wdata),
      .cfg_ack      (cfg_ack),
      .cfg_rdata    (cfg_rdata),
      .psr_imme     (psr_imme),
      .psr_rm       (psr_rm),
      .tlb_en       (tlb_en),
      .tlb_we_lo    (tlb_we_lo),
      .tlb_we_hi    (tlb_we_hi),
      .tlb_idx      (tlb_idx),
      .tlb_wdata    (tlb_wdata),
      .tlb_rdata_lo (tlb_rdata_lo),
      .tlb_rdata_hi (tlb_rdata_hi)
   );

   itlb_ram i_itlb_ram (
      .clk          (clk),
      .rst          (rst),
      .lookup_en    (lookup_en),
      .lookup_idx   (lookup_idx),
      .lookup_lo    (lookup_lo),
      .lookup_hi    (lookup_hi),
      .cfg_en       (tlb_en),
      .cfg_we_lo    (tlb_we_lo),
      .cfg_we_hi    (tlb_we_hi),
      .cfg_idx      (tlb_idx),
      .cfg_wdata    (tlb_wdata),
      .cfg_rdata_lo (tlb_rdata_lo),
      .cfg_rdata_hi (tlb_rdata_hi)
   );

   immu_translate i_immu_translate (
      .clk         (clk),
      .rst         (rst),
      .fetch_valid (fetch_valid),
      .fetch_ready (fetch_ready),
      .fetch_addr  (fetch_addr),
      .psr_imme    (psr_imme),
      .psr_rm      (psr_rm),
      .lookup_en   (lookup_en),
      .lookup_idx  (lookup_idx),
      .lookup_lo   (lookup_lo),
      .lookup_hi   (lookup_hi),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_addr    (out_addr),
      .out_exc     (out_exc)
   );

endmodule

`default_nettype wire

//--- tests/immu_tb.sv
// Instruction MMU testbench
// Vector file reader, req/ack host driver, fetch driver with random back-pressure

`timescale 1ns/1ps
`default_nettype none

module immu_tb;

   // Cycles any single wait may take
   localparam int TIMEOUT = 100;

   logic               clk;
   logic               rst;
   logic               fetch_valid;
   logic               fetch_ready;
   immu_pkg::addr_t    fetch_addr;
   logic               out_valid;
   logic               out_ready;
   immu_pkg::addr_t    out_addr;
   immu_pkg::exc_t     out_exc;
   logic               cfg_req;
   logic               cfg_write;
   immu_pkg::cfg_sel_t cfg_sel;
   immu_pkg::tlb_idx_t cfg_idx;
   immu_pkg::word_t    cfg_wdata;
   logic               cfg_ack;
   immu_pkg::word_t    cfg_rdata;

   // Fetches gathered from consecutive F lines
   immu_pkg::addr_t batch_addr[$];
   immu_pkg::addr_t batch_exp_addr[$];
   immu_pkg::exc_t  batch_exp_exc[$];

   // Results still owed by the DUT, in issue order
   immu_pkg::addr_t exp_addr_q[$];
   immu_pkg::exc_t  exp_exc_q[$];

   int fetch_checks;
   int word_checks;

   immu_top i_immu_top (
      .clk         (clk),
      .rst         (rst),
      .fetch_valid (fetch_valid),
      .fetch_ready (fetch_ready),
      .fetch_addr  (fetch_addr),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_addr    (out_addr),
      .out_exc     (out_exc),
      .cfg_req     (cfg_req),
      .cfg_write   (cfg_write),
      .cfg_sel     (cfg_sel),
      .cfg_idx     (cfg_idx),
      .cfg_wdata   (cfg_wdata),
      .cfg_ack     (cfg_ack),
      .cfg_rdata   (cfg_rdata)
   );

   // 4 ns clock
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("ERROR time=%0t %s", $time, why);
      $display("Simulation finished: FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (expected !== actual) begin
         $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic check_addr(input string name, input immu_pkg::addr_t expected,
                             input immu_pkg::addr_t actual);
      if (expected !== actual) begin
         $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic check_exc(input string name, input immu_pkg::exc_t expected,
                            input immu_pkg::exc_t actual);
      if (expected !== actual) begin
         $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic check_word(input string name, input immu_pkg::word_t expected,
                             input immu_pkg::word_t actual);
      if (expected !== actual) begin
         $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   // One four-phase access, entered and left 1 ns after a rising edge
   task automatic host_access(input logic write, input immu_pkg::cfg_sel_t sel,
                              input immu_pkg::tlb_idx_t idx, input immu_pkg::word_t wdata,
                              output immu_pkg::word_t rdata);
      int wait_cycles;
      cfg_req     = 1'b1;
      cfg_write   = write;
      cfg_sel     = sel;
      cfg_idx     = idx;
      cfg_wdata   = wdata;
      wait_cycles = 0;
      // Ack sampled mid-cycle
      @(negedge clk);
      while (!cfg_ack) begin
         wait_cycles++;
         if (wait_cycles > TIMEOUT) begin
            abort_run("cfg_ack did not rise after cfg_req");
         end
         @(negedge clk);
      end
      rdata = cfg_rdata;
      @(posedge clk);
      #1;
      cfg_req     = 1'b0;
      wait_cycles = 0;
      @(negedge clk);
      while (cfg_ack) begin
         wait_cycles++;
         if (wait_cycles > TIMEOUT) begin
            abort_run("cfg_ack did not fall after cfg_req was dropped");
         end
         @(negedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   // Issue the gathered fetches back to back and check every result
   task automatic run_fetches();
      int              issued;
      int              ready_wait;
      int              out_wait;
      logic            fire_in;
      logic            fire_out;
      logic            held;
      logic            stage_full;
      immu_pkg::addr_t held_addr;
      immu_pkg::exc_t  held_exc;
      immu_pkg::addr_t exp_a;
      immu_pkg::exc_t  exp_e;
      issued     = 0;
      ready_wait = 0;
      out_wait   = 0;
      held       = 1'b0;
      stage_full = 1'b0;
      held_addr  = '0;
      held_exc   = '0;
      if (batch_addr.size() > 0) begin
         fetch_valid = 1'b1;
         fetch_addr  = batch_addr[0];
      end
      while (issued < batch_addr.size() || exp_addr_q.size() > 0) begin
         // Handshakes seen mid-cycle complete on the next rising edge
         @(negedge clk);
         // One-item stage, full from the accepting edge until taken
         check_flag("out_valid", stage_full, out_valid);
         check_flag("fetch_ready", !stage_full || out_ready, fetch_ready);
         fire_in  = fetch_valid && fetch_ready;
         fire_out = out_valid && out_ready;
         // A stalled result may not move
         if (held) begin
            check_addr("out_addr while stalled", held_addr, out_addr);
            check_exc("out_exc while stalled", held_exc, out_exc);
         end
         if (fire_out) begin
            if (exp_addr_q.size() == 0) begin
               abort_run("output transfer with no fetch outstanding");
            end
            exp_a = exp_addr_q.pop_front();
            exp_e = exp_exc_q.pop_front();
            check_addr("out_addr", exp_a, out_addr);
            check_exc("out_exc", exp_e, out_exc);
            fetch_checks++;
         end
         held       = out_valid && !out_ready;
         held_addr  = out_addr;
         held_exc   = out_exc;
         stage_full = fire_in || (stage_full && !fire_out);
         if (fire_in) begin
            exp_addr_q.push_back(batch_exp_addr[issued]);
            exp_exc_q.push_back(batch_exp_exc[issued]);
            issued++;
         end
         // Cycle timeouts for both sides
         if (fetch_valid && !fire_in) begin
            ready_wait++;
         end else begin
            ready_wait = 0;
         end
         if (exp_addr_q.size() > 0 && !fire_out) begin
            out_wait++;
         end else begin
            out_wait = 0;
         end
         if (ready_wait > TIMEOUT) begin
            abort_run("fetch_ready stayed low while a fetch was offered");
         end
         if (out_wait > TIMEOUT) begin
            abort_run("no output transfer for an outstanding fetch");
         end
         @(posedge clk);
         #1;
         if (fire_in) begin
            if (issued < batch_addr.size()) begin
               fetch_addr = batch_addr[issued];
            end else begin
               fetch_valid = 1'b0;
               fetch_addr  = '0;
            end
         end
         // Back-pressure about one cycle in four
         out_ready = ($urandom % 4) != 0;
      end
      batch_addr.delete();
      batch_exp_addr.delete();
      batch_exp_exc.delete();
      out_ready = 1'b1;
   endtask

   initial begin
      int              fd;
      int              rc;
      int              n;
      string           line;
      logic [7:0]      op;
      logic [31:0]     a;
      logic [31:0]     b;
      logic [31:0]     c;
      immu_pkg::word_t rdata;
      void'($urandom(32'h23ee_34e3));
      rst          = 1'b1;
      fetch_valid  = 1'b0;
      fetch_addr   = '0;
      out_ready    = 1'b1;
      cfg_req      = 1'b0;
      cfg_write    = 1'b0;
      cfg_sel      = '0;
      cfg_idx      = '0;
      cfg_wdata    = '0;
      fetch_checks = 0;
      word_checks  = 0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      fd = $fopen("tests/immu_vectors.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open tests/immu_vectors.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         op   = 8'h00;
         n    = 0;
         rc   = $fgets(line, fd);
         if (rc > 0) begin
            n = $sscanf(line, "%c %h %h %h", op, a, b, c);
         end
         if (n == 4 && op == "F") begin
            batch_addr.push_back(a);
            batch_exp_addr.push_back(b);
            batch_exp_exc.push_back(c[1:0]);
         end else if (n == 4 && (op == "W" || op == "R")) begin
            // No fetch in flight during a configuration access
            run_fetches();
            if (op == "W") begin
               host_access(1'b1, a[1:0], b[3:0], c, rdata);
            end else begin
               host_access(1'b0, a[1:0], b[3:0], '0, rdata);
               check_word("cfg_rdata", c, rdata);
               word_checks++;
            end
         end else if (n >= 1 && op != "#" && op != 8'h0a && op != 8'h0d) begin
            abort_run({"malformed vector line ", line});
         end
      end
      $fclose(fd);
      run_fetches();
      if (fetch_checks > 0 && word_checks > 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("ERROR time=%0t no results were checked", $time);
         $display("Simulation finished: FAIL");
         $fatal(1, "no results were checked");
      end
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/immu_pkg.sv
source/itlb_ram.sv
source/immu_csr.sv
source/immu_translate.sv
source/immu_top.sv
tests/immu_tb.sv

//--- Makefile
# Verilator simulation of the instruction MMU

VERILATOR ?= verilator
TOP       ?= immu_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# Build, run, then scan the log for the verdict
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/immu_vectors.txt
# Columns are an opcode and three hex fields
# W sel idx wdata / R sel idx expected / F vaddr expected_addr expected_exc
# sel 0 PSR, 1 ID, 2 TLBL, 3 TLBH; exc bit 0 miss, bit 1 page fault

# Reset state, ID holds the TLB index width, PSR has rm set
R 1 0 00000004
R 0 0 00000002
# MMU off passes addresses through
F 12345678 12345678 0
F 00002abc 00002abc 0
F fffffffc fffffffc 0

# Set 1 maps VPN 00001 to PPN 00041 with rx and ux
W 2 1 00002001
W 3 1 00082018
# Set 2 maps VPN 00012 to PPN 7abcd with rx only
W 2 2 00024001
W 3 2 f579a010
# Set 3 maps VPN 00003 to PPN 00100 with ux only
W 2 3 00006001
W 3 3 00200008
# Set 4 written with the valid bit clear
W 2 4 00008000
W 3 4 000aa018
# Set 5 maps VPN 00005 to PPN 00777
W 2 5 0000a001
W 3 5 00eee018
R 2 1 00002001
R 3 1 00082018
R 2 2 00024001
R 3 2 f579a010
R 2 3 00006001
R 3 3 00200008
R 2 4 00008000
R 3 5 00eee018

# MMU on in supervisor mode
W 0 0 00000003
R 0 0 00000003
F 00002abc 00082abc 0
F 00025f00 f579bf00 0
F 00003ff0 00083ff0 0
F 0000a004 00eee004 0
F 00007ffc 00000180 2
F 00008010 00000100 1
F 0002a004 00000100 1
F 00012000 00000100 1
F 80002000 00000100 1
F 00002000 00082000 0

# User mode
W 0 0 00000001
R 0 0 00000001
F 00002abc 00082abc 0
F 00025f00 00000180 2
F 00007ffc 00201ffc 0
F 0000a004 00eee004 0
F 00008010 00000100 1
F 00006000 00200000 0

# Set 2 gains ux and translates in user mode
W 3 2 f579a018
R 3 2 f579a018
F 00024000 f579a000 0
F 00025f00 f579bf00 0
# MMU off again
W 0 0 00000000
F 00025f00 00025f00 0
R 1 0 00000004
